/* Makefile */
# verilator flow for the soc fabric

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module tb_top -f src.f

sim:
	verilator --binary --timing --top-module tb_top -Mdir obj_dir -f src.f
	@out="$$(./obj_dir/Vtb_top)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation finished: PASS$$"

clean:
	rm -rf obj_dir

/* src.f */
src/soc_pkg.sv
src/apb_decoder.sv
src/main_memory.sv
src/timer_bank.sv
src/plic.sv
src/soc_top.sv
testbench/tb_sva.sv
testbench/tb_checker.sv
testbench/tb_top.sv

/* src/apb_decoder.sv */
// apb one master address decoder
`timescale 1ns/100ps

module apb_decoder (
    input  soc_pkg::apb_req_t host_req_i,
    output soc_pkg::apb_rsp_t host_rsp_o,
    output soc_pkg::apb_req_t mem_req_o,
    input  soc_pkg::apb_rsp_t mem_rsp_i,
    output soc_pkg::apb_req_t timer_req_o,
    input  soc_pkg::apb_rsp_t timer_rsp_i,
    output soc_pkg::apb_req_t plic_req_o,
    input  soc_pkg::apb_rsp_t plic_rsp_i
);

    import soc_pkg::*;

    region_e region;    // target of the current address
    logic    access;    // host in access phase

    assign access = host_req_i.psel & host_req_i.penable;

    // top nibble picks the slave
    always_comb begin
        case (host_req_i.paddr[ADDR_WIDTH-1 -: 4])
            MEM_BASE[ADDR_WIDTH-1 -: 4]:   region = REGION_MEM;
            TIMER_BASE[ADDR_WIDTH-1 -: 4]: region = REGION_TIMER;
            PLIC_BASE[ADDR_WIDTH-1 -: 4]:  region = REGION_PLIC;
            default:                       region = REGION_NONE;  // 0x3 and up
        endcase
    end

    ////////////////////////////////////////////////////////////
    // request fan out
    ////////////////////////////////////////////////////////////

    // same request to everyone, psel only to the hit
    always_comb begin
        mem_req_o        = host_req_i;
        timer_req_o      = host_req_i;
        plic_req_o       = host_req_i;
        mem_req_o.psel   = host_req_i.psel & (region == REGION_MEM);
        timer_req_o.psel = host_req_i.psel & (region == REGION_TIMER);
        plic_req_o.psel  = host_req_i.psel & (region == REGION_PLIC);
    end

    ////////////////////////////////////////////////////////////
    // response mux
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (region)
            REGION_MEM:   host_rsp_o = mem_rsp_i;
            REGION_TIMER: host_rsp_o = timer_rsp_i;
            REGION_PLIC:  host_rsp_o = plic_rsp_i;
            default: begin
                // unmapped, error in first access cycle
                host_rsp_o.prdata  = '0;
                host_rsp_o.pready  = access;
                host_rsp_o.pslverr = access;
            end
        endcase
    end

endmodule : apb_decoder

/* src/main_memory.sv */
// apb main memory, one wait state
`timescale 1ns/100ps

module main_memory #(
    parameter int unsigned MEM_WORDS = 256
) (
    input  logic              soc_clk_i,
    input  logic              rst_n_i,
    input  soc_pkg::apb_req_t req_i,
    output soc_pkg::apb_rsp_t rsp_o
);

    import soc_pkg::*;

    localparam int unsigned IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    typedef enum logic {
        MEM_IDLE,   // waiting for an access phase
        MEM_WAIT    // the one wait state is over, ready now
    } mem_state_e;

    mem_state_e            state_q;
    mem_state_e            state_d;
    logic [DATA_WIDTH-1:0] mem_q [MEM_WORDS];
    logic [DATA_WIDTH-1:0] rdata_q;     // word fetched in first access cycle
    logic [IDX_W-1:0]      word_idx;
    logic                  access;

    assign access   = req_i.psel & req_i.penable;
    assign word_idx = req_i.paddr[2 +: IDX_W];  // byte offset dropped, wraps at depth

    ////////////////////////////////////////////////////////////
    // wait state fsm
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            MEM_IDLE: if (access) state_d = MEM_WAIT;
            MEM_WAIT: state_d = MEM_IDLE;   // transfer completes here
            default:  state_d = MEM_IDLE;
        endcase
    end

    always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) state_q <= MEM_IDLE;
        else          state_q <= state_d;
    end

    // storage
    always_ff @(posedge soc_clk_i) begin
        if (state_q == MEM_IDLE && access) rdata_q <= mem_q[word_idx];
        if (state_q == MEM_WAIT && access && req_i.pwrite) begin
            mem_q[word_idx] <= req_i.pwdata;    // write on completion
        end
    end

    assign rsp_o.prdata  = rdata_q;
    assign rsp_o.pready  = (state_q == MEM_WAIT);   // second access cycle
    assign rsp_o.pslverr = 1'b0;                    // every word is valid

endmodule : main_memory

/* src/plic.sv */
// platform interrupt controller
`timescale 1ns/100ps

module plic (
    input  logic              soc_clk_i,
    input  logic              rst_n_i,
    input  soc_pkg::apb_req_t req_i,
    output soc_pkg::apb_rsp_t rsp_o,
    input  logic [1:0]        intr_src_i,   // bit n -> id n+1
    output logic              irq_o
);

    import soc_pkg::*;

    localparam int unsigned OFF_W = ADDR_WIDTH - 6;

    localparam logic [OFF_W-1:0] OFF_ENABLE  = OFF_W'(0);  // 0x0
    localparam logic [OFF_W-1:0] OFF_PENDING = OFF_W'(1);  // 0x4, read only
    localparam logic [OFF_W-1:0] OFF_CLAIM   = OFF_W'(2);  // 0x8

    logic [NUM_IRQ_SRC-1:0]  src_vec;     // indexed by id
    logic [NUM_IRQ_SRC-1:0]  enable_q;
    logic [NUM_IRQ_SRC-1:0]  pending_q;
    logic [NUM_IRQ_SRC-1:0]  active;
    logic [NUM_IRQ_SRC-1:0]  claim_clr;
    logic [IRQ_ID_WIDTH-1:0] claim_id;
    logic [OFF_W-1:0]        word_off;
    logic                    access;
    logic                    claim_rd;
    logic [DATA_WIDTH-1:0]   rdata;

    assign src_vec  = NUM_IRQ_SRC'({intr_src_i, 1'b0});   // id 0 never fires
    assign word_off = req_i.paddr[ADDR_WIDTH-5:2];
    assign access   = req_i.psel & req_i.penable;
    assign claim_rd = access & ~req_i.pwrite & (word_off == OFF_CLAIM);

    assign active = pending_q & enable_q;
    assign irq_o  = |active;

    // lowest enabled pending id wins, 0 when idle
    always_comb begin
        claim_id = '0;
        for (int i = NUM_IRQ_SRC - 1; i > 0; i--) begin
            if (active[i]) claim_id = IRQ_ID_WIDTH'(i);
        end
    end

    assign claim_clr = claim_rd ? (NUM_IRQ_SRC'(1) << claim_id) : '0;

    always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            enable_q  <= '0;
            pending_q <= '0;
        end else begin
            if (access && req_i.pwrite && word_off == OFF_ENABLE) begin
                enable_q <= req_i.pwdata[NUM_IRQ_SRC-1:0] & ~NUM_IRQ_SRC'(1);
            end
            // a new pulse survives a claim of the same id
            pending_q <= (pending_q & ~claim_clr) | src_vec;
        end
    end

    always_comb begin
        case (word_off)
            OFF_ENABLE:  rdata = DATA_WIDTH'(enable_q);
            OFF_PENDING: rdata = DATA_WIDTH'(pending_q);
            OFF_CLAIM:   rdata = DATA_WIDTH'(claim_id);
            default:     rdata = '0;
        endcase
    end

    assign rsp_o.prdata  = rdata;
    assign rsp_o.pready  = access;      // first access cycle
    assign rsp_o.pslverr = 1'b0;

endmodule : plic

/* src/soc_pkg.sv */
// soc fabric shared definitions

package soc_pkg;

    ////////////////////////////////////////////////////////////
    // bus widths
    ////////////////////////////////////////////////////////////

    localparam int unsigned ADDR_WIDTH   = 32;
    localparam int unsigned DATA_WIDTH   = 32;

    // interrupt sources, id 0 reserved
    localparam int unsigned NUM_IRQ_SRC  = 4;
    localparam int unsigned IRQ_ID_WIDTH = $clog2(NUM_IRQ_SRC);   // 2 bit ids

    ////////////////////////////////////////////////////////////
    // memory map, decoded on addr[31:28]
    ////////////////////////////////////////////////////////////

    localparam logic [ADDR_WIDTH-1:0] MEM_BASE   = 32'h0000_0000;
    localparam logic [ADDR_WIDTH-1:0] TIMER_BASE = 32'h1000_0000;
    localparam logic [ADDR_WIDTH-1:0] PLIC_BASE  = 32'h2000_0000;

    typedef enum logic [1:0] {
        REGION_MEM   = 2'd0,
        REGION_TIMER = 2'd1,
        REGION_PLIC  = 2'd2,
        REGION_NONE  = 2'd3     // unmapped, decoder answers with error
    } region_e;

    ////////////////////////////////////////////////////////////
    // apb channels
    ////////////////////////////////////////////////////////////

    // master -> slave, 67 bits
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] paddr;
        logic                  pwrite;
        logic [DATA_WIDTH-1:0] pwdata;
        logic                  psel;
        logic                  penable;
    } apb_req_t;

    // slave -> master, 34 bits
    typedef struct packed {
        logic [DATA_WIDTH-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

endpackage : soc_pkg

/* src/soc_top.sv */
// soc fabric top level
`timescale 1ns/100ps

module soc_top #(
    parameter int unsigned MEM_WORDS = 256      // main memory depth, power of two
) (
    input  logic              soc_clk_i,
    input  logic              rst_n_i,
    input  soc_pkg::apb_req_t host_req_i,       // external host, only master
    output soc_pkg::apb_rsp_t host_rsp_o,
    output logic              irq_o             // platform interrupt out
);

    import soc_pkg::*;

    // decoder <-> slaves
    apb_req_t   mem_req;
    apb_rsp_t   mem_rsp;
    apb_req_t   timer_req;
    apb_rsp_t   timer_rsp;
    apb_req_t   plic_req;
    apb_rsp_t   plic_rsp;

    // timer expiry pulses -> plic sources 1 and 2
    logic [1:0] timer_irq;

    ////////////////////////////////////////////////////////////
    // bus
    ////////////////////////////////////////////////////////////

    apb_decoder apb_decoder_u (
        .host_req_i  ( host_req_i ),
        .host_rsp_o  ( host_rsp_o ),
        .mem_req_o   ( mem_req    ),
        .mem_rsp_i   ( mem_rsp    ),
        .timer_req_o ( timer_req  ),
        .timer_rsp_i ( timer_rsp  ),
        .plic_req_o  ( plic_req   ),
        .plic_rsp_i  ( plic_rsp   )
    );

    ////////////////////////////////////////////////////////////
    // slaves
    ////////////////////////////////////////////////////////////

    main_memory #(
        .MEM_WORDS ( MEM_WORDS )
    ) main_memory_u (
        .soc_clk_i ( soc_clk_i ),
        .rst_n_i   ( rst_n_i   ),
        .req_i     ( mem_req   ),
        .rsp_o     ( mem_rsp   )
    );

    timer_bank timer_bank_u (
        .soc_clk_i   ( soc_clk_i ),
        .rst_n_i     ( rst_n_i   ),
        .req_i       ( timer_req ),
        .rsp_o       ( timer_rsp ),
        .timer_irq_o ( timer_irq )  // bit n = timer n expired
    );

    plic plic_u (
        .soc_clk_i  ( soc_clk_i ),
        .rst_n_i    ( rst_n_i   ),
        .req_i      ( plic_req  ),
        .rsp_o      ( plic_rsp  ),
        .intr_src_i ( timer_irq ),  // ids 1 and 2
        .irq_o      ( irq_o     )
    );

endmodule : soc_top

/* src/timer_bank.sv */
// two one-shot compare timers
`timescale 1ns/100ps

module timer_bank (
    input  logic              soc_clk_i,
    input  logic              rst_n_i,
    input  soc_pkg::apb_req_t req_i,
    output soc_pkg::apb_rsp_t rsp_o,
    output logic [1:0]        timer_irq_o   // one cycle pulse per expiry
);

    import soc_pkg::*;

    localparam int unsigned NUM_TIMERS = 2;
    localparam int unsigned OFF_W      = ADDR_WIDTH - 6;    // word offset in region

    // register word offsets
    localparam logic [OFF_W-1:0] OFF_CTRL0  = OFF_W'(0);   // 0x00
    localparam logic [OFF_W-1:0] OFF_CMP0   = OFF_W'(1);   // 0x04
    localparam logic [OFF_W-1:0] OFF_CTRL1  = OFF_W'(2);   // 0x08
    localparam logic [OFF_W-1:0] OFF_CMP1   = OFF_W'(3);   // 0x0c
    localparam logic [OFF_W-1:0] OFF_STATUS = OFF_W'(4);   // 0x10, w1c

    logic [NUM_TIMERS-1:0] en_q;        // control bit 0
    logic [NUM_TIMERS-1:0] status_q;    // sticky expiry flags
    logic [DATA_WIDTH-1:0] cnt_q [NUM_TIMERS];
    logic [DATA_WIDTH-1:0] cmp_q [NUM_TIMERS];
    logic [NUM_TIMERS-1:0] hit;
    logic [NUM_TIMERS-1:0] ctrl_wr;
    logic [NUM_TIMERS-1:0] cmp_wr;
    logic                  stat_wr;
    logic                  wr_en;
    logic [OFF_W-1:0]      word_off;
    logic [DATA_WIDTH-1:0] rdata;

    assign word_off = req_i.paddr[ADDR_WIDTH-5:2];
    assign wr_en    = req_i.psel & req_i.penable & req_i.pwrite;

    assign ctrl_wr = {wr_en && word_off == OFF_CTRL1, wr_en && word_off == OFF_CTRL0};
    assign cmp_wr  = {wr_en && word_off == OFF_CMP1, wr_en && word_off == OFF_CMP0};
    assign stat_wr = wr_en && word_off == OFF_STATUS;

    ////////////////////////////////////////////////////////////
    // counters
    ////////////////////////////////////////////////////////////

    // match while running
    always_comb begin
        for (int t = 0; t < NUM_TIMERS; t++) begin
            hit[t] = en_q[t] && (cnt_q[t] == cmp_q[t]);
        end
    end

    assign timer_irq_o = hit;   // en clears on the next edge

    always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_q     <= '0;
            status_q <= '0;
        end else begin
            for (int t = 0; t < NUM_TIMERS; t++) begin
                if (ctrl_wr[t])  en_q[t] <= req_i.pwdata[0];
                else if (hit[t]) en_q[t] <= 1'b0;       // one shot
                // expiry beats a clear in the same cycle
                if (hit[t])                                 status_q[t] <= 1'b1;
                else if (stat_wr && req_i.pwdata[t])        status_q[t] <= 1'b0;
            end
        end
    end

    always_ff @(posedge soc_clk_i) begin
        for (int t = 0; t < NUM_TIMERS; t++) begin
            if (cmp_wr[t]) cmp_q[t] <= req_i.pwdata;
            if (ctrl_wr[t])                cnt_q[t] <= '0;  // restart from zero
            else if (en_q[t] && !hit[t])   cnt_q[t] <= cnt_q[t] + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // read back
    ////////////////////////////////////////////////////////////

    always_comb begin
        rdata = '0;     // holes read zero
        case (word_off)
            OFF_CTRL0:  rdata[0]   = en_q[0];
            OFF_CMP0:   rdata      = cmp_q[0];
            OFF_CTRL1:  rdata[0]   = en_q[1];
            OFF_CMP1:   rdata      = cmp_q[1];
            OFF_STATUS: rdata[1:0] = status_q;
            default:    ;
        endcase
    end

    assign rsp_o.prdata  = rdata;
    assign rsp_o.pready  = req_i.psel & req_i.penable;  // no wait states
    assign rsp_o.pslverr = 1'b0;

endmodule : timer_bank

/* testbench/soc_golden.txt */
# op addr data expect irq (hex), W write, R read and compare, I wait for irq_o
# pslverr is expected high only for address regions 3 and up
W 1000000C 00000004 00000000 0
W 10000008 00000001 00000000 0
W 00000000 A5A50001 00000000 0
W 00000004 5A5A0002 00000000 0
W 000003FC DEADBEEF 00000000 0
W 00000010 01234567 00000000 0
R 00000000 00000000 A5A50001 0
R 00000004 00000000 5A5A0002 0
R 000003FC 00000000 DEADBEEF 0
R 00000400 00000000 A5A50001 0
W 00000804 12345678 00000000 0
R 00000004 00000000 12345678 0
R 00000010 00000000 01234567 0
R 30000000 00000000 00000000 0
W 40000010 FFFFFFFF 00000000 0
R F0000004 00000000 00000000 0
R 20000004 00000000 00000004 0
R 10000010 00000000 00000002 0
W 10000010 00000002 00000000 0
R 10000010 00000000 00000000 0
W 20000000 00000002 00000000 0
R 20000000 00000000 00000002 0
W 10000004 00000014 00000000 0
W 10000000 00000001 00000000 0
R 10000000 00000000 00000001 0
I 00000000 00000000 00000000 1
R 10000010 00000000 00000001 1
R 10000000 00000000 00000000 1
R 10000004 00000000 00000014 1
W 20000000 00000006 00000000 0
R 20000008 00000000 00000001 1
R 20000008 00000000 00000002 1
R 20000008 00000000 00000000 0
R 20000004 00000000 00000000 0
W 10000010 00000001 00000000 0
R 10000010 00000000 00000000 0

/* testbench/tb_checker.sv */
// apb transfer and interrupt checker
`timescale 1ns/100ps

module tb_checker (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  soc_pkg::apb_req_t req_i,
    input  soc_pkg::apb_rsp_t rsp_i,
    input  logic              irq_i,
    input  logic              timeout_i,    // an I line gave up
    input  int                line_i,
    input  logic              done_i,
    output int                err_total_o
);

    import soc_pkg::*;

    localparam string EXP_FILE = "testbench/soc_golden.txt";
    localparam int    MAX_EXP  = 64;

    // W and R lines only in file order
    byte         op_q   [MAX_EXP];
    logic [31:0] addr_q [MAX_EXP];
    logic [31:0] exp_q  [MAX_EXP];
    logic        irq_q  [MAX_EXP];
    int          line_q [MAX_EXP];
    int          n_exp;
    int          idx;
    int          acc_cycles;    // access cycles of the transfer in flight
    int          n_checks;
    int          n_err;
    int          n_timeout;
    int          n_missing;
    int          n_file;

    assign err_total_o = n_err + n_timeout + n_missing + n_file;

    // slave picked by the top address nibble
    function automatic region_e region_of(input logic [31:0] addr);
        case (addr[31:28])
            4'h0:    return REGION_MEM;
            4'h1:    return REGION_TIMER;
            4'h2:    return REGION_PLIC;
            default: return REGION_NONE;
        endcase
    endfunction

    initial begin : read_expect
        int          fd;
        int          lnum;
        string       line;
        byte         op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        logic [31:0] q;
        n_exp      = 0;
        idx        = 0;
        acc_cycles = 0;
        n_checks   = 0;
        n_err      = 0;
        n_timeout  = 0;
        n_missing  = 0;
        n_file     = 0;
        lnum       = 0;
        fd         = $fopen(EXP_FILE, "r");
        if (fd == 0) begin
            $display("checker could not open %s", EXP_FILE);
            n_file = 1;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                lnum++;
                if (line.len() < 3 || line[0] == "#") continue;
                if ($sscanf(line, "%c %h %h %h %h", op, a, d, e, q) != 5) continue;
                if ((op == "W" || op == "R") && n_exp < MAX_EXP) begin
                    op_q[n_exp]   = op;
                    addr_q[n_exp] = a;
                    exp_q[n_exp]  = e;
                    irq_q[n_exp]  = q[0];
                    line_q[n_exp] = lnum;
                    n_exp++;
                end
            end
            $fclose(fd);
        end
    end

    ////////////////////////////////////////////////////////////
    // compare on completion
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        n_checks++;
        if (exp_v !== act_v) begin
            n_err++;
            $display("Error: %s expected %h actual %h", name, exp_v, act_v);
        end
    endtask

    task automatic check_transfer();
        string   tag;
        region_e r;
        int      exp_cycles;
        if (idx >= n_exp) begin
            n_err++;
            $display("a transfer to %h completed with no golden line left", req_i.paddr);
        end else begin
            tag        = $sformatf("line %0d %c %h", line_q[idx], op_q[idx], addr_q[idx]);
            r          = region_of(addr_q[idx]);
            exp_cycles = (r == REGION_MEM) ? 2 : 1;     // memory adds one wait state
            check_value({tag, " access cycles"}, 32'(exp_cycles), 32'(acc_cycles));
            // unmapped regions must answer with pslverr
            check_value({tag, " pslverr"}, 32'(r == REGION_NONE), 32'(rsp_i.pslverr));
            if (op_q[idx] == "R") begin
                check_value({tag, " prdata"}, exp_q[idx], rsp_i.prdata);
                check_value({tag, " irq_o"}, 32'(irq_q[idx]), 32'(irq_i));
            end
            idx++;
        end
    endtask

    always @(posedge clk_i) begin
        if (rst_n_i && req_i.psel && req_i.penable) begin
            acc_cycles++;
            if (rsp_i.pready) begin
                check_transfer();
                acc_cycles = 0;
            end
        end
        if (timeout_i) begin
            n_timeout++;
            $display("line %0d: irq_o never rose within the wait limit", line_i);
        end
    end

    always @(posedge done_i) begin
        if (idx != n_exp) begin
            n_missing = n_exp - idx;
            $display("%0d expected transfers never completed", n_exp - idx);
        end
        $display("checks %0d, errors %0d, timeouts %0d, missing %0d",
                 n_checks, n_err, n_timeout, n_missing);
    end

endmodule : tb_checker

/* testbench/tb_sva.sv */
// apb protocol and reset assertions
`timescale 1ns/100ps

module tb_sva (
    input logic              clk_i,
    input logic              rst_n_i,
    input soc_pkg::apb_req_t req_i,
    input soc_pkg::apb_rsp_t rsp_i,
    input logic              irq_i
);

    import soc_pkg::*;

    // master holds everything while the slave stalls
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_i.psel && req_i.penable && !rsp_i.pready |=> $stable(req_i))
        else $error("apb request changed during a wait state");

    // setup is always followed by access
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_i.psel && !req_i.penable |=> req_i.psel && req_i.penable)
        else $error("apb setup phase not followed by access phase");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_i.penable |-> req_i.psel)
        else $error("apb penable without psel");

    assert property (@(posedge clk_i) !rst_n_i |-> !rsp_i.pready && !irq_i)
        else $error("pready or irq_o high during reset");

endmodule : tb_sva

bind soc_top tb_sva u_sva (
    .clk_i   ( soc_clk_i  ),
    .rst_n_i ( rst_n_i    ),
    .req_i   ( host_req_i ),
    .rsp_i   ( host_rsp_o ),
    .irq_i   ( irq_o      )
);

/* testbench/tb_top.sv */
// soc fabric testbench top
`timescale 1ns/100ps

module tb_top;

    import soc_pkg::*;

    localparam string OPS_FILE = "testbench/soc_golden.txt";
    localparam int    MAX_OPS  = 64;
    localparam int    IRQ_WAIT = 200;     // cycles an I line may wait
    localparam int    OP_BUDGET = 250;    // watchdog cycles per golden line

    logic        clk;
    logic        rst_n;
    apb_req_t    host_req;
    apb_rsp_t    host_rsp;
    logic        irq;
    logic        wait_timeout;    // one cycle pulse to the checker
    int          wait_line;
    logic        run_done;
    logic        ops_loaded;
    int          err_total;

    // operations in file order
    byte         op_q   [MAX_OPS];
    logic [31:0] addr_q [MAX_OPS];
    logic [31:0] data_q [MAX_OPS];
    int          line_q [MAX_OPS];
    int          n_ops;

    ////////////////////////////////////////////////////////////
    // clock, dut, checker
    ////////////////////////////////////////////////////////////

    initial clk = 1'b0;
    always #5 clk = ~clk;     // 10 ns

    soc_top #(
        .MEM_WORDS ( 256 )
    ) u_dut (
        .soc_clk_i  ( clk      ),
        .rst_n_i    ( rst_n    ),
        .host_req_i ( host_req ),
        .host_rsp_o ( host_rsp ),
        .irq_o      ( irq      )
    );

    tb_checker u_checker (
        .clk_i       ( clk          ),
        .rst_n_i     ( rst_n        ),
        .req_i       ( host_req     ),
        .rsp_i       ( host_rsp     ),
        .irq_i       ( irq          ),
        .timeout_i   ( wait_timeout ),
        .line_i      ( wait_line    ),
        .done_i      ( run_done     ),
        .err_total_o ( err_total    )
    );

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    // each line holds op addr data expect irq
    task automatic load_ops();
        int          fd;
        int          lnum;
        int          got;
        string       line;
        byte         op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        logic [31:0] q;
        fd    = $fopen(OPS_FILE, "r");
        n_ops = 0;
        lnum  = 0;
        if (fd == 0) begin
            $display("cannot open stimulus file %s", OPS_FILE);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                lnum++;
                if (line.len() < 3 || line[0] == "#") continue;
                got = $sscanf(line, "%c %h %h %h %h", op, a, d, e, q);
                if (got == 5 && n_ops < MAX_OPS) begin
                    op_q[n_ops]   = op;
                    addr_q[n_ops] = a;
                    data_q[n_ops] = d;
                    line_q[n_ops] = lnum;
                    n_ops++;
                end
            end
            $fclose(fd);
        end
    endtask

    // one apb transfer that ends on the negedge after completion
    task automatic apb_xfer(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic write);
        logic ready;
        @(negedge clk);
        host_req.paddr   = addr;     // setup phase
        host_req.pwrite  = write;
        host_req.pwdata  = wdata;
        host_req.psel    = 1'b1;
        host_req.penable = 1'b0;
        @(negedge clk);
        host_req.penable = 1'b1;     // access phase
        ready = 1'b0;
        while (!ready) begin
            #1;
            ready = host_rsp.pready;  // settled well before posedge
            @(negedge clk);
        end
        host_req.psel    = 1'b0;
        host_req.penable = 1'b0;
    endtask

    task automatic wait_for_irq(input int lnum);
        int k;
        k = 0;
        while (!irq && k < IRQ_WAIT) begin
            @(negedge clk);
            k++;
        end
        if (!irq) begin
            wait_line    = lnum;
            wait_timeout = 1'b1;      // checker reports it
            @(negedge clk);
            wait_timeout = 1'b0;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        host_req     = '0;
        rst_n        = 1'b0;
        wait_timeout = 1'b0;
        wait_line    = 0;
        run_done     = 1'b0;
        ops_loaded   = 1'b0;
        load_ops();
        ops_loaded = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < n_ops; i++) begin
            case (op_q[i])
                "W":     apb_xfer(addr_q[i], data_q[i], 1'b1);
                "R":     apb_xfer(addr_q[i], 32'h0, 1'b0);
                "I":     wait_for_irq(line_q[i]);
                default: ;
            endcase
        end
        repeat (2) @(negedge clk);
        run_done = 1'b1;              // checker prints its summary
        #1;
        if (err_total == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // watchdog budget scales with the golden file
    initial begin
        wait (ops_loaded);
        repeat (8 + (n_ops + 1) * OP_BUDGET) @(posedge clk);
        $display("watchdog expired, the run did not finish in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule : tb_top
